// ==== sms_host_bridge.f ====
+incdir+common
common/sms_pkg.sv
loader/cart_loader.sv
loader/cheat_code_loader.sv
logic/clock_enable_gen.sv
logic/backup_ram_sync.sv
logic/sms_host_bridge.sv
tb/tb_sms_host_bridge.sv

// ==== Bender.yml ====
package:
  name: sms_host_bridge

export_include_dirs:
  - common

sources:
  - files:
      - common/sms_pkg.sv
      - loader/cart_loader.sv
      - loader/cheat_code_loader.sv
      - logic/clock_enable_gen.sv
      - logic/backup_ram_sync.sv
      - logic/sms_host_bridge.sv
  - target: test
    files:
      - tb/tb_sms_host_bridge.sv

// ==== tb/tb_sms_host_bridge.sv ====
// ==============================
// SMS host bridge testbench
// Downloads, ROM handshake, cheats, enables and backup
// ==============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module tb_sms_host_bridge;

	logic                        clk_sys;
	logic                        RESET;
	sms_pkg::dl_bus_t            dl;
	logic                        rom_wr_ack;
	logic [`SMS_ROM_ADDR_W-1:0]  core_rom_addr;
	sms_pkg::sd_img_t            img;
	logic                        sd_ack;
	logic                        bk_load_req;
	logic                        bk_save_req;
	logic                        autosave_en;
	logic                        osd_open;
	logic                        nvram_we;
	logic                        dl_wait;
	sms_pkg::rom_wr_t            rom_wr;
	logic [`SMS_ROM_ADDR_W-1:0]  rom_rd_addr;
	logic                        gg;
	sms_pkg::cheat_code_u        cheat_code;
	logic                        cheat_valid;
	logic                        cheat_clear;
	sms_pkg::ce_t                ce;
	logic [31:0]                 sd_lba;
	logic                        sd_rd;
	logic                        sd_wr;
	logic                        bk_busy;
	logic                        bk_pending;
	logic                        core_reset;
	logic                        activity_led;

	integer      seed = 32'h26f;
	int          check_count = 0;
	int          error_count = 0;
	int          test_num = 1;
	int          test_err_start = 0;
	int          rom_writes = 0;
	int          sd_rd_reqs = 0;
	int          sd_wr_reqs = 0;
	int          valid_pulses = 0;
	int          clear_pulses = 0;
	int          reset_low_busy = 0;
	string       name_q[$];
	logic [63:0] exp_q[$];
	logic [63:0] got_q[$];
	event        check_ev;
	logic [7:0]  cart_bytes [0:2047];
	logic [7:0]  cheat_bytes [0:15];

	sms_host_bridge u_sms_host_bridge (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl            (dl),
		.rom_wr_ack    (rom_wr_ack),
		.core_rom_addr (core_rom_addr),
		.img           (img),
		.sd_ack        (sd_ack),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave_en   (autosave_en),
		.osd_open      (osd_open),
		.nvram_we      (nvram_we),
		.dl_wait       (dl_wait),
		.rom_wr        (rom_wr),
		.rom_rd_addr   (rom_rd_addr),
		.gg            (gg),
		.cheat_code    (cheat_code),
		.cheat_valid   (cheat_valid),
		.cheat_clear   (cheat_clear),
		.ce            (ce),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_busy       (bk_busy),
		.bk_pending    (bk_pending),
		.core_reset    (core_reset),
		.activity_led  (activity_led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==============================
	// Reference functions
	// ==============================
	// Enable pulses in n cycles
	// Select 0 is cpu, 1 pix, 2 vdp and 3 sp
	function automatic int ce_count_ref(input int which, input int n);
		int c;
		int ph;
		int cnt;
		cnt = 0;
		for (c = 0; c < n; c++) begin
			ph = c % `SMS_CE_DIV;
			if ((which == 0 && (ph == 9 || ph == 24)) || (which == 1 && ph % 10 == 9) ||
			    (which == 2 && ph % 5 == 4) || (which == 3 && ph % 2 == 1)) begin
				cnt++;
			end
		end
		return cnt;
	endfunction

	// Host address ends at n so bit 9 of n is the header flag
	function automatic logic [`SMS_ROM_ADDR_W-1:0] rd_addr_ref(
		input logic [`SMS_ROM_ADDR_W-1:0] a, input int n);
		int k;
		logic [`SMS_ROM_ADDR_W-1:0] m;
		logic [`SMS_ROM_ADDR_W-1:0] m512;
		m = '0;
		m512 = '0;
		// OR of every address written
		for (k = 1; k < n; k++) begin
			m = m | k[`SMS_ROM_ADDR_W-1:0];
		end
		// OR of the addresses past the header, less the header size
		for (k = `SMS_HEADER_BYTES + 1; k < n; k++) begin
			m512 = m512 | (k[`SMS_ROM_ADDR_W-1:0] - 22'd512);
		end
		if (n[9]) begin
			return (a + 22'd512) & m512;
		end
		return a & m;
	endfunction

	// Field f covers lanes 4f to 4f+3
	function automatic logic [31:0] cheat_field_ref(input int f);
		return {cheat_bytes[4*f+3], cheat_bytes[4*f+2], cheat_bytes[4*f+1], cheat_bytes[4*f]};
	endfunction

	// ==============================
	// Comparing process and models
	// ==============================
	task automatic expect_value(input string nm, input logic [63:0] e, input logic [63:0] g);
		name_q.push_back(nm);
		exp_q.push_back(e);
		got_q.push_back(g);
		-> check_ev;
	endtask

	initial begin : compare_proc
		string       nm;
		logic [63:0] e;
		logic [63:0] g;
		forever begin
			@(check_ev);
			while (name_q.size() > 0) begin
				nm = name_q.pop_front();
				e = exp_q.pop_front();
				g = got_q.pop_front();
				check_count++;
				if (g !== e) begin
					error_count++;
					$display("MISMATCH %s: expected 0x%0h, got 0x%0h", nm, e, g);
				end
			end
		end
	end

	// ROM memory acknowledges after 1 to 4 cycles
	initial begin : rom_model
		int delay;
		forever begin
			@(negedge clk_sys);
			if (!RESET && (rom_wr.req !== rom_wr_ack)) begin
				expect_value("rom_wr.addr", rom_writes, rom_wr.addr);
				expect_value("rom_wr.data", cart_bytes[rom_writes], rom_wr.data);
				rom_writes++;
				delay = 1 + ({$random(seed)} % 4);
				repeat (delay) @(posedge clk_sys);
				rom_wr_ack <= rom_wr.req;
			end
		end
	end

	initial begin : sd_model
		forever begin
			@(negedge clk_sys);
			if (!RESET && (sd_rd || sd_wr) && !sd_ack) begin
				expect_value("sd_lba", sd_rd_reqs + sd_wr_reqs, sd_lba);
				if (sd_rd) begin
					sd_rd_reqs++;
				end else begin
					sd_wr_reqs++;
				end
				repeat (2) @(posedge clk_sys);
				sd_ack <= 1'b1;
				repeat (3) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (cheat_valid === 1'b1) begin
			valid_pulses++;
		end
		if (cheat_clear === 1'b1) begin
			clear_pulses++;
		end
	end

	// ==============================
	// Helper tasks
	// ==============================
	task automatic abort_run(input string reason);
		$display("ERROR: %s", reason);
		$display("Checks failed");
		$finish;
	endtask

	task automatic end_test(input string nm);
		@(negedge clk_sys);
		if (error_count == test_err_start) begin
			$display("Test %0d %s: pass", test_num, nm);
		end else begin
			$display("Test %0d %s: FAIL, %0d errors", test_num, nm, error_count - test_err_start);
		end
		test_num++;
		test_err_start = error_count;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int t;
		t = 0;
		@(negedge clk_sys);
		while (bk_busy !== level) begin
			t++;
			if (t > limit) begin
				abort_run("bk_busy did not reach the expected level in time");
			end
			@(negedge clk_sys);
			if (bk_busy && !core_reset) begin
				reset_low_busy++;
			end
		end
	endtask

	task automatic await_transfer(input int exp_rd, input int exp_wr, input logic is_load);
		wait_busy(1'b1, 10);
		expect_value("activity_led", 1, activity_led);
		reset_low_busy = 0;
		wait_busy(1'b0, 4000);
		expect_value("sd read requests", exp_rd, sd_rd_reqs);
		expect_value("sd write requests", exp_wr, sd_wr_reqs);
		if (is_load) begin
			expect_value("core_reset low during load", 0, reset_low_busy);
			expect_value("core_reset", 0, core_reset);
		end
	endtask

	task automatic dl_start(input logic [7:0] idx);
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.index    <= idx;
		dl.addr     <= '0;
		rom_writes = 0;
	endtask

	task automatic dl_end();
		@(posedge clk_sys);
		dl.download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// Host holds each beat back while dl_wait is high
	task automatic dl_cart_bytes(input int n);
		int i;
		int t;
		int reset_low;
		reset_low = 0;
		for (i = 0; i < n; i++) begin
			@(posedge clk_sys);
			cart_bytes[i] = 8'($random(seed));
			dl.wr   <= 1'b1;
			dl.addr <= 25'(i);
			dl.dout <= cart_bytes[i];
			@(posedge clk_sys);
			dl.wr   <= 1'b0;
			dl.addr <= 25'(i + 1);
			@(negedge clk_sys);
			expect_value("dl_wait", 1, dl_wait);
			expect_value("activity_led", 1, activity_led);
			t = 0;
			while (dl_wait) begin
				if (!core_reset) begin
					reset_low++;
				end
				t++;
				if (t > 12) begin
					abort_run("dl_wait stayed high after the ROM write was acknowledged");
				end
				@(negedge clk_sys);
			end
		end
		expect_value("rom writes", n, rom_writes);
		expect_value("core_reset low during download", 0, reset_low);
	endtask

	task automatic check_rd_addr(input int n);
		int k;
		logic [`SMS_ROM_ADDR_W-1:0] a;
		for (k = 0; k < 8; k++) begin
			@(posedge clk_sys);
			a = 22'($random(seed));
			core_rom_addr <= a;
			@(negedge clk_sys);
			expect_value("rom_rd_addr", rd_addr_ref(a, n), rom_rd_addr);
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================
	initial begin : stimulus
		int i;
		int last_cpu;
		int n_cpu;
		int n_pix;
		int n_vdp;
		int n_sp;
		RESET = 1'b1;
		dl = '0;
		rom_wr_ack = 1'b0;
		core_rom_addr = '0;
		img = '0;
		sd_ack = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		autosave_en = 1'b0;
		osd_open = 1'b0;
		nvram_we = 1'b0;

		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		expect_value("dl_wait", 0, dl_wait);
		expect_value("ce", 0, ce);
		expect_value("cheat_valid", 0, cheat_valid);
		expect_value("cheat_clear", 0, cheat_clear);
		expect_value("sd_rd", 0, sd_rd);
		expect_value("sd_wr", 0, sd_wr);
		expect_value("bk_busy", 0, bk_busy);
		expect_value("bk_pending", 0, bk_pending);
		@(posedge clk_sys);
		RESET <= 1'b0;

		// First pattern slot lands one cycle after the counter starts at 0
		@(posedge clk_sys);
		n_cpu = 0;
		n_pix = 0;
		n_vdp = 0;
		n_sp = 0;
		last_cpu = -1;
		for (i = 0; i < 300; i++) begin
			@(negedge clk_sys);
			if (ce.cpu) begin
				if (last_cpu >= 0) begin
					expect_value("ce.cpu gap", `SMS_CE_DIV / 2, i - last_cpu);
				end
				last_cpu = i;
				n_cpu++;
			end
			n_pix += ce.pix;
			n_vdp += ce.vdp;
			n_sp += ce.sp;
		end
		expect_value("ce.cpu count", ce_count_ref(0, 300), n_cpu);
		expect_value("ce.pix count", ce_count_ref(1, 300), n_pix);
		expect_value("ce.vdp count", ce_count_ref(2, 300), n_vdp);
		expect_value("ce.sp count", ce_count_ref(3, 300), n_sp);
		end_test("clock enables");

		dl_start(8'd1);
		dl_cart_bytes(300);
		dl_end();
		expect_value("gg", 0, gg);
		check_rd_addr(300);
		end_test("cartridge without header");

		dl_start(8'd2);
		dl_cart_bytes(1536);
		dl_end();
		expect_value("gg", 1, gg);
		check_rd_addr(1536);
		end_test("cartridge with header");

		valid_pulses = 0;
		clear_pulses = 0;
		dl_start(`SMS_IDX_CHEAT);
		for (i = 0; i < 16; i++) begin
			@(posedge clk_sys);
			cheat_bytes[i] = 8'($random(seed));
			dl.wr   <= 1'b1;
			dl.addr <= 25'(i);
			dl.dout <= cheat_bytes[i];
			@(posedge clk_sys);
			dl.wr   <= 1'b0;
		end
		dl_end();
		expect_value("cheat_clear pulses", 1, clear_pulses);
		expect_value("cheat_valid pulses", 1, valid_pulses);
		expect_value("cheat_code.field.flags", cheat_field_ref(0), cheat_code.field.flags);
		expect_value("cheat_code.field.address", cheat_field_ref(1), cheat_code.field.address);
		expect_value("cheat_code.field.compare", cheat_field_ref(2), cheat_code.field.compare);
		expect_value("cheat_code.field.replace", cheat_field_ref(3), cheat_code.field.replace);
		end_test("cheat record");

		// Writable image mounted while the cartridge loads
		dl_start(8'd1);
		repeat (2) @(posedge clk_sys);
		img.mounted  <= 1'b1;
		img.readonly <= 1'b0;
		@(posedge clk_sys);
		img.mounted  <= 1'b0;
		dl_cart_bytes(16);
		dl_end();
		sd_rd_reqs = 0;
		sd_wr_reqs = 0;
		@(posedge clk_sys);
		bk_save_req <= 1'b1;
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
		await_transfer(0, `SMS_BK_SECTORS, 1'b0);
		sd_rd_reqs = 0;
		sd_wr_reqs = 0;
		@(posedge clk_sys);
		bk_load_req <= 1'b1;
		@(posedge clk_sys);
		bk_load_req <= 1'b0;
		await_transfer(`SMS_BK_SECTORS, 0, 1'b1);
		end_test("backup save and load");

		sd_rd_reqs = 0;
		sd_wr_reqs = 0;
		@(posedge clk_sys);
		autosave_en <= 1'b1;
		nvram_we    <= 1'b1;
		@(posedge clk_sys);
		nvram_we    <= 1'b0;
		@(negedge clk_sys);
		expect_value("bk_pending", 1, bk_pending);
		expect_value("activity_led", 1, activity_led);
		@(posedge clk_sys);
		osd_open <= 1'b1;
		await_transfer(0, `SMS_BK_SECTORS, 1'b0);
		@(negedge clk_sys);
		expect_value("bk_pending", 0, bk_pending);
		expect_value("activity_led", 0, activity_led);
		end_test("autosave");

		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== logic/sms_host_bridge.sv ====
// ==============================
// SMS host bridge
// Download decode, core reset and the loader and backup blocks
// ==============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module sms_host_bridge (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  sms_pkg::dl_bus_t            dl,
	input  logic                        rom_wr_ack,
	input  logic [`SMS_ROM_ADDR_W-1:0]  core_rom_addr,
	input  sms_pkg::sd_img_t            img,
	input  logic                        sd_ack,
	input  logic                        bk_load_req,
	input  logic                        bk_save_req,
	input  logic                        autosave_en,
	input  logic                        osd_open,
	input  logic                        nvram_we,
	output logic                        dl_wait,
	output sms_pkg::rom_wr_t            rom_wr,
	output logic [`SMS_ROM_ADDR_W-1:0]  rom_rd_addr,
	output logic                        gg,
	output sms_pkg::cheat_code_u        cheat_code,
	output logic                        cheat_valid,
	output logic                        cheat_clear,
	output sms_pkg::ce_t                ce,
	output logic [31:0]                 sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic                        bk_busy,
	output logic                        bk_pending,
	output logic                        core_reset,
	output logic                        activity_led
);

	sms_pkg::dl_target_e target;
	logic                cart_active;
	logic                bk_loading;

	// ==============================
	// Download target decode
	// ==============================
	always_comb begin
		if (!dl.download) begin
			target = sms_pkg::DL_NONE;
		end else if (dl.index == `SMS_IDX_CHEAT) begin
			target = sms_pkg::DL_CHEAT;
		end else if ((dl.index != `SMS_IDX_SYSMODE) && (dl.index != `SMS_IDX_DSW)) begin
			target = sms_pkg::DL_CART;
		end else begin
			target = sms_pkg::DL_OTHER;
		end
	end

	assign cart_active = (target == sms_pkg::DL_CART);

	// Console held in reset while its ROM or backup RAM is loading
	assign core_reset   = RESET | cart_active | bk_loading;
	assign activity_led = cart_active | bk_busy | (bk_pending & autosave_en);

	cart_loader u_cart_loader (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl            (dl),
		.target        (target),
		.rom_wr_ack    (rom_wr_ack),
		.core_rom_addr (core_rom_addr),
		.dl_wait       (dl_wait),
		.rom_wr        (rom_wr),
		.rom_rd_addr   (rom_rd_addr),
		.gg            (gg)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl          (dl),
		.target      (target),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	clock_enable_gen u_clock_enable_gen (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.ce      (ce)
	);

	backup_ram_sync u_backup_ram_sync (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_active (cart_active),
		.img         (img),
		.sd_ack      (sd_ack),
		.bk_load_req (bk_load_req),
		.bk_save_req (bk_save_req),
		.autosave_en (autosave_en),
		.osd_open    (osd_open),
		.nvram_we    (nvram_we),
		.sd_lba      (sd_lba),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.bk_busy     (bk_busy),
		.bk_loading  (bk_loading),
		.bk_pending  (bk_pending)
	);

endmodule

// ==== logic/backup_ram_sync.sv ====
// ==============================
// Backup RAM sync
// Save and load sequencer over 64 SD sectors, autosave flag
// ==============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module backup_ram_sync (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              cart_active,
	input  sms_pkg::sd_img_t  img,
	input  logic              sd_ack,
	input  logic              bk_load_req,
	input  logic              bk_save_req,
	input  logic              autosave_en,
	input  logic              osd_open,
	input  logic              nvram_we,
	output logic [31:0]       sd_lba,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic              bk_busy,
	output logic              bk_loading,
	output logic              bk_pending
);

	logic old_cart;
	logic bk_ena;
	logic save_cond;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic load_start;
	logic save_start;
	logic cart_end;

	// ==============================
	// Enable and autosave flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_cart   <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			old_cart <= cart_active;
			if (!old_cart && cart_active) begin
				bk_ena <= 1'b0;
			end else if (cart_active && img.mounted && !img.readonly) begin
				bk_ena <= 1'b1;
			end

			if (bk_ena && !osd_open && nvram_we) begin
				bk_pending <= 1'b1;
			end else if (bk_busy) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// Autosave fires when the menu opens with unsaved data
	assign save_cond  = bk_save_req | (bk_pending & osd_open & autosave_en);
	assign load_start = bk_ena & bk_load_req & ~old_load;
	assign save_start = bk_ena & save_cond & ~old_save;
	assign cart_end   = bk_ena & old_cart & ~cart_active & (|img.size);

	// ==============================
	// Sector sequencer
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= bk_load_req;
			old_save <= save_cond;
			old_ack  <= sd_ack;

			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_start || save_start || cart_end) begin
					// Load wins if both arrive together
					bk_busy    <= 1'b1;
					bk_loading <= load_start | cart_end;
					sd_lba     <= '0;
					sd_rd      <= load_start | cart_end;
					sd_wr      <= ~(load_start | cart_end);
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_lba == 32'(`SMS_BK_SECTORS - 1)) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

// ==== logic/clock_enable_gen.sv ====
// ==============================
// Clock-enable generator
// Fixed divide-by-30 pattern for CPU, VDP, pixel and sound
// ==============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module clock_enable_gen (
	input  logic         clk_sys,
	input  logic         RESET,
	output sms_pkg::ce_t ce
);

	localparam int CNT_W = $clog2(`SMS_CE_DIV);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cnt <= '0;
			ce  <= '0;
		end else begin
			if (cnt == CNT_W'(`SMS_CE_DIV - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end

			// Sound runs at half rate
			ce.sp  <= cnt[0];
			ce.vdp <= 1'b0;
			ce.pix <= 1'b0;
			ce.cpu <= 1'b0;
			case (cnt)
				CNT_W'(4), CNT_W'(14): begin
					ce.vdp <= 1'b1;
				end
				CNT_W'(9): begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
					ce.cpu <= 1'b1;
				end
				CNT_W'(19), CNT_W'(29): begin
					ce.vdp <= 1'b1;
					ce.pix <= 1'b1;
				end
				// CPU phase sits here rather than at 29
				CNT_W'(24): begin
					ce.vdp <= 1'b1;
					ce.cpu <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== loader/cheat_code_loader.sv ====
// ==============================
// Cheat code loader
// Collects 16 download bytes into one code word
// ==============================
`timescale 1ns/1ps

module cheat_code_loader (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  sms_pkg::dl_bus_t     dl,
	input  sms_pkg::dl_target_e  target,
	output sms_pkg::cheat_code_u cheat_code,
	output logic                 cheat_valid,
	output logic                 cheat_clear
);

	logic cheat_beat;

	assign cheat_beat = dl.wr & (target == sms_pkg::DL_CHEAT);

	// Byte n of the record goes to lane n
	always_ff @(posedge clk_sys) begin
		if (cheat_beat) begin
			cheat_code.lane[dl.addr[3:0]] <= dl.dout;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= cheat_beat && (dl.addr[3:0] == 4'hF);
			// Any download restarting at zero drops the old codes
			cheat_clear <= dl.wr && (target != sms_pkg::DL_NONE) && (dl.addr == '0);
		end
	end

endmodule

// ==== loader/cart_loader.sv ====
// ==============================
// Cartridge loader
// ROM write handshake, address masks and read translation
// ==============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module cart_loader (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  sms_pkg::dl_bus_t            dl,
	input  sms_pkg::dl_target_e         target,
	input  logic                        rom_wr_ack,
	input  logic [`SMS_ROM_ADDR_W-1:0]  core_rom_addr,
	output logic                        dl_wait,
	output sms_pkg::rom_wr_t            rom_wr,
	output logic [`SMS_ROM_ADDR_W-1:0]  rom_rd_addr,
	output logic                        gg
);

	localparam int AW = `SMS_ROM_ADDR_W;

	logic                         cart_active;
	logic                         old_cart;
	logic                         cart_beat;
	logic                         wr_req;
	logic [`SMS_ROM_WADDR_W-1:0]  wr_addr;
	logic [7:0]                   wr_data;
	logic [AW-1:0]                cart_mask;
	logic [AW-1:0]                cart_mask512;
	logic                         cart_sz512;

	assign cart_active = (target == sms_pkg::DL_CART);
	assign cart_beat   = dl.wr & cart_active;

	// ==============================
	// Write handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_cart <= 1'b0;
			dl_wait  <= 1'b0;
			wr_req   <= 1'b0;
		end else begin
			old_cart <= cart_active;
			if (cart_beat) begin
				dl_wait <= 1'b1;
				wr_req  <= ~wr_req;
			end else if (dl_wait && (wr_req == rom_wr_ack)) begin
				dl_wait <= 1'b0;
			end
		end
	end

	// Address advances once the memory has caught up
	always_ff @(posedge clk_sys) begin
		if (!old_cart && cart_active) begin
			wr_addr <= '0;
		end else if (!cart_beat && dl_wait && (wr_req == rom_wr_ack)) begin
			wr_addr <= wr_addr + 1'b1;
		end
		if (cart_beat) begin
			wr_data <= dl.dout;
		end
	end

	assign rom_wr = '{req: wr_req, addr: wr_addr, data: wr_data};

	// ==============================
	// Cartridge size masks
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (cart_beat) begin
			cart_mask    <= (dl.addr == '0) ? '0 : (cart_mask | dl.addr[AW-1:0]);
			cart_mask512 <= (dl.addr == `SMS_HEADER_BYTES) ? '0 :
			                (cart_mask512 | (dl.addr[AW-1:0] - AW'(`SMS_HEADER_BYTES)));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg         <= 1'b0;
			cart_sz512 <= 1'b0;
		end else begin
			if (cart_beat) begin
				gg <= (dl.index[4:0] == `SMS_IDX_GG);
			end
			// Last address still on the bus when the download ends
			if (old_cart && !cart_active) begin
				cart_sz512 <= dl.addr[9];
			end
		end
	end

	assign rom_rd_addr = cart_sz512 ?
		((core_rom_addr + AW'(`SMS_HEADER_BYTES)) & cart_mask512) :
		(core_rom_addr & cart_mask);

endmodule

// ==== common/sms_pkg.sv ====
// ==============================
// SMS host bridge types
// Download beat, ROM write port, enables, image and cheat word
// ==============================
`include "sms_defines.svh"

package sms_pkg;

	// One beat of the host download stream
	typedef struct packed {
		logic                        wr;
		logic                        download;
		logic [7:0]                  index;
		logic [`SMS_DL_ADDR_W-1:0]   addr;
		logic [7:0]                  dout;
	} dl_bus_t;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_CART,
		DL_CHEAT,
		DL_OTHER
	} dl_target_e;

	// ROM write port, req is a toggle
	typedef struct packed {
		logic                        req;
		logic [`SMS_ROM_WADDR_W-1:0] addr;
		logic [7:0]                  data;
	} rom_wr_t;

	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} ce_t;

	typedef struct packed {
		logic        mounted;
		logic        readonly;
		logic [63:0] size;
	} sd_img_t;

	// Flags sit in lanes 0-3, replace in lanes 12-15
	typedef struct packed {
		logic [31:0] replace;
		logic [31:0] compare;
		logic [31:0] address;
		logic [31:0] flags;
	} cheat_fields_t;

	typedef union packed {
		logic [15:0][7:0] lane;
		cheat_fields_t    field;
	} cheat_code_u;

endpackage

// ==== common/sms_defines.svh ====
// ==============================
// SMS host bridge constants
// Widths, download indices, divider and backup sizes
// ==============================
`ifndef SMS_DEFINES_SVH
`define SMS_DEFINES_SVH

// Bus widths
`define SMS_DL_ADDR_W     25
`define SMS_ROM_ADDR_W    22
`define SMS_ROM_WADDR_W   24

// Download indices
`define SMS_IDX_CHEAT     8'hFF
`define SMS_IDX_SYSMODE   8'd4
`define SMS_IDX_DSW       8'd254
// Compared against index[4:0] only
`define SMS_IDX_GG        5'd2

// Cartridge header in front of some images
`define SMS_HEADER_BYTES  512

// Clock-enable period in clk_sys cycles
`define SMS_CE_DIV        30

// Backup RAM transfer length in sectors
`define SMS_BK_SECTORS    64

`endif
